// File: fifo_stim.txt
# test push_v push_data pop_v | expected after the edge: count full empty pop_data_v pop_data
# data in hex, pop_data is checked once the first pop has happened
1 0 0000 0 0 0 1 0 0000
2 1 00a1 0 1 0 0 0 0000
2 1 00a2 0 2 0 0 0 0000
2 0 0000 1 1 0 0 1 00a1
2 0 0000 1 0 0 1 1 00a2
2 0 0000 0 0 0 1 0 00a2
3 1 00b0 0 1 0 0 0 00a2
3 1 00b1 0 2 0 0 0 00a2
3 1 00b2 0 3 0 0 0 00a2
3 1 00b3 0 4 0 0 0 00a2
3 1 00b4 0 5 0 0 0 00a2
3 1 00b5 0 6 0 0 0 00a2
3 1 00b6 0 7 0 0 0 00a2
3 1 00b7 0 8 1 0 0 00a2
3 1 0bad 0 8 1 0 0 00a2
3 0 0000 1 7 0 0 1 00b0
3 0 0000 1 6 0 0 1 00b1
3 0 0000 1 5 0 0 1 00b2
3 0 0000 1 4 0 0 1 00b3
4 1 00c0 1 4 0 0 1 00b4
4 1 00c1 1 4 0 0 1 00b5
4 1 00c2 1 4 0 0 1 00b6
4 1 00c3 1 4 0 0 1 00b7
4 1 00c4 1 4 0 0 1 00c0
4 0 0000 1 3 0 0 1 00c1
4 0 0000 1 2 0 0 1 00c2
4 0 0000 1 1 0 0 1 00c3
4 0 0000 1 0 0 1 1 00c4
5 0 0000 1 0 0 1 0 00c4
6 0 0000 0 0 0 1 0 00c4
6 1 00d6 0 1 0 0 0 00c4
6 0 0000 1 0 0 1 1 00d6
end

// File: sources.f
fifo_pkg.sv
clock_gate.sv
ram_1r1w_sync_array.sv
ram_1r1w_sync.sv
fifo_ptr_ctrl.sv
fifo_1r1w_sync.sv
tb_clock_gen.sv
tb_fifo.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it into sim.log, then search the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fifo -f sources.f -o sim_fifo \
   && ./obj_dir/sim_fifo > sim.log 2>&1 \
   || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: tb_fifo.sv
// ====================
// testbench for the sync FIFO
// stim and expected values from fifo_stim.txt
// per-test summary, check counts, cycle timeout
// ====================

`timescale 1ns/1ns

module tb_fifo;

   import fifo_pkg::*;

   logic   clk_lo;
   logic   rst_n;
   logic   push_v;
   data_t  push_data;
   logic   pop_v;
   logic   full;
   logic   empty;
   logic   pop_data_v;
   data_t  pop_data;
   count_t count;

   // nine fields per stim line in one flat queue
   int stim_q [$];
   int n_lines     = 0;
   int cycles      = 0;
   int cycle_limit = 20;
   int pass_cnt    = 0;
   int fail_cnt    = 0;
   int test_errs   = 0;
   bit seen_pop    = 1'b0;
   bit end_found   = 1'b0;

   tb_clock_gen i_tb_clock_gen
      (
      .clk_o   (clk_lo),
      .rst_n_o (rst_n)
      );

   fifo_1r1w_sync
      #(
      .width_p   (data_width_c),
      .els_p     (depth_c),
      .gate_en_p (1'b1)
      )
   i_fifo_1r1w_sync
      (
      .clk_lo       (clk_lo),
      .rst_n_i      (rst_n),
      .push_v_i     (push_v),
      .push_data_i  (push_data),
      .full_o       (full),
      .pop_v_i      (pop_v),
      .pop_data_o   (pop_data),
      .pop_data_v_o (pop_data_v),
      .empty_o      (empty),
      .count_o      (count)
      );

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      begin
         pass_cnt++;
      end
      else
      begin
         $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, got);
         fail_cnt++;
         test_errs++;
      end
   endtask

   task automatic load_stim();
      int    fd;
      int    k;
      int    f [9];
      string line;
      fd = $fopen("fifo_stim.txt", "r");
      if (fd == 0)
      begin
         $display("could not open fifo_stim.txt");
         fail_cnt++;
         return;
      end
      while (!$feof(fd) && !end_found)
      begin
         line = "";
         void'($fgets(line, fd));
         // skip blank lines and the column notes
         if (line.len() < 2 || line[0] == "#")
         begin
            continue;
         end
         if (line.substr(0, 2) == "end")
         begin
            end_found = 1'b1;
            continue;
         end
         k = $sscanf(line, "%d %h %h %h %d %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
         if (k != 9)
         begin
            $display("stim line has only %0d of 9 fields: %s", k, line);
            fail_cnt++;
         end
         else
         begin
            foreach (f[j])
            begin
               stim_q.push_back(f[j]);
            end
         end
      end
      $fclose(fd);
      if (!end_found)
      begin
         $display("stim file ran out of lines before its end marker");
         fail_cnt++;
      end
   endtask

   // compare the DUT state after the edge with one stim line
   task automatic check_line(input int i);
      int b;
      b = i * 9;
      check_val("count_o", 32'(count), stim_q[b+4]);
      check_val("full_o", 32'(full), stim_q[b+5]);
      check_val("empty_o", 32'(empty), stim_q[b+6]);
      check_val("pop_data_v_o", 32'(pop_data_v), stim_q[b+7]);
      if (stim_q[b+7] != 0)
      begin
         seen_pop = 1'b1;
      end
      // pop data holds between pops, so it is known once the first pop is done
      if (seen_pop)
      begin
         check_val("pop_data_o", 32'(pop_data), stim_q[b+8]);
      end
   endtask

   initial
   begin
      int i;
      push_v    = 1'b0;
      push_data = '0;
      pop_v     = 1'b0;
      load_stim();
      n_lines     = stim_q.size() / 9;
      cycle_limit = n_lines + 20;
      wait (rst_n);
      // levels left by reset before the first operation
      check_val("count_o", 32'(count), 32'd0);
      check_val("full_o", 32'(full), 32'd0);
      check_val("empty_o", 32'(empty), 32'd1);
      check_val("pop_data_v_o", 32'(pop_data_v), 32'd0);
      for (i = 0; i < n_lines; i++)
      begin
         push_v    = (stim_q[i*9+1] != 0);
         push_data = data_t'(stim_q[i*9+2]);
         pop_v     = (stim_q[i*9+3] != 0);
         @(negedge clk_lo);
         check_line(i);
         if (i == n_lines - 1 || stim_q[(i+1)*9] != stim_q[i*9])
         begin
            $display("test %0d done, %0d errors", stim_q[i*9], test_errs);
            test_errs = 0;
         end
      end
      push_v = 1'b0;
      pop_v  = 1'b0;
      $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt > 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

   always @(posedge clk_lo)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

endmodule

// File: tb_clock_gen.sv
// ====================
// testbench clock and reset
// 40 ns clock, reset low for 5 cycles
// ====================

`timescale 1ns/1ns

module tb_clock_gen
   (
   output logic clk_o,
   output logic rst_n_o
   );

   initial
   begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      repeat (5) @(posedge clk_o);
      // release on a falling edge, well away from the sampling edge
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

   always #20 clk_o = ~clk_o;

endmodule

// File: fifo_1r1w_sync.sv
// ====================
// synchronous FIFO top level
// pointer control plus 1r1w sync-read RAM
// ====================

`timescale 1ns/1ns

module fifo_1r1w_sync
   #(
   parameter int width_p   = fifo_pkg::data_width_c,
   parameter int els_p     = fifo_pkg::depth_c,
   parameter bit gate_en_p = 1'b1
   )
   (
   input  logic             clk_lo,
   input  logic             rst_n_i,

   // push side
   input  logic             push_v_i,
   input  fifo_pkg::data_t  push_data_i,
   output logic             full_o,

   // pop side
   input  logic             pop_v_i,
   output fifo_pkg::data_t  pop_data_o,
   output logic             pop_data_v_o,
   output logic             empty_o,

   output fifo_pkg::count_t count_o
   );

   import fifo_pkg::*;

   // accepted requests and pointers from the control
   logic  ram_w_v;
   addr_t ram_w_addr;
   logic  ram_r_v;
   addr_t ram_r_addr;

   fifo_ptr_ctrl
      #(
      .els_p (els_p)
      )
   i_fifo_ptr_ctrl
      (
      .clk_lo       (clk_lo),
      .rst_n_i      (rst_n_i),
      .push_v_i     (push_v_i),
      .pop_v_i      (pop_v_i),
      .w_v_o        (ram_w_v),
      .w_addr_o     (ram_w_addr),
      .r_v_o        (ram_r_v),
      .r_addr_o     (ram_r_addr),
      .full_o       (full_o),
      .empty_o      (empty_o),
      .count_o      (count_o),
      .pop_data_v_o (pop_data_v_o)
      );

   // push data goes straight to the write port,
   // the registered read data is the pop data
   ram_1r1w_sync
      #(
      .width_p   (width_p),
      .els_p     (els_p),
      .gate_en_p (gate_en_p)
      )
   i_ram_1r1w_sync
      (
      .clk_lo   (clk_lo),
      .w_v_i    (ram_w_v),
      .w_addr_i (ram_w_addr),
      .w_data_i (push_data_i),
      .r_v_i    (ram_r_v),
      .r_addr_i (ram_r_addr),
      .r_data_o (pop_data_o)
      );

endmodule

// File: fifo_ptr_ctrl.sv
// ====================
// FIFO pointer and level control
// push and pop qualification against full and empty
// read and write pointers, fill count, pop data valid
// ====================

`timescale 1ns/1ns

module fifo_ptr_ctrl
   #(
   parameter int els_p = fifo_pkg::depth_c
   )
   (
   input  logic             clk_lo,
   input  logic             rst_n_i,

   // requests from outside
   input  logic             push_v_i,
   input  logic             pop_v_i,

   // RAM strobes and addresses
   output logic             w_v_o,
   output fifo_pkg::addr_t  w_addr_o,
   output logic             r_v_o,
   output fifo_pkg::addr_t  r_addr_o,

   // levels
   output logic             full_o,
   output logic             empty_o,
   output fifo_pkg::count_t count_o,
   output logic             pop_data_v_o
   );

   import fifo_pkg::*;

   // pointers wrap here, so a depth that is no power of two works
   localparam addr_t  last_addr_lp  = addr_t'(els_p - 1);
   localparam count_t full_count_lp = count_t'(els_p);

   logic   push_ok;
   logic   pop_ok;
   addr_t  w_ptr_r;
   addr_t  r_ptr_r;
   count_t count_r;
   logic   pop_v_r;

   // levels follow the count directly
   assign full_o  = (count_r == full_count_lp);
   assign empty_o = (count_r == '0);

   // refused requests are dropped here and never reach the RAM
   assign push_ok = push_v_i & ~full_o;
   assign pop_ok  = pop_v_i & ~empty_o;

   // write pointer
   always_ff @(posedge clk_lo)
   begin
      if (!rst_n_i)
      begin
         w_ptr_r <= '0;
      end
      else if (push_ok)
      begin
         w_ptr_r <= (w_ptr_r == last_addr_lp) ? '0 : w_ptr_r + 1'b1;
      end
   end

   // read pointer
   always_ff @(posedge clk_lo)
   begin
      if (!rst_n_i)
      begin
         r_ptr_r <= '0;
      end
      else if (pop_ok)
      begin
         r_ptr_r <= (r_ptr_r == last_addr_lp) ? '0 : r_ptr_r + 1'b1;
      end
   end

   // fill count
   // push and pop together leave it where it is
   always_ff @(posedge clk_lo)
   begin
      if (!rst_n_i)
      begin
         count_r <= '0;
      end
      else
      begin
         case ({push_ok, pop_ok})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   // the RAM puts the word out one cycle after the read strobe,
   // so the valid pulse trails the accepted pop by one cycle
   always_ff @(posedge clk_lo)
   begin
      if (!rst_n_i)
      begin
         pop_v_r <= 1'b0;
      end
      else
      begin
         pop_v_r <= pop_ok;
      end
   end

   assign w_v_o        = push_ok;
   assign w_addr_o     = w_ptr_r;
   assign r_v_o        = pop_ok;
   assign r_addr_o     = r_ptr_r;
   assign count_o      = count_r;
   assign pop_data_v_o = pop_v_r;

endmodule

// File: ram_1r1w_sync.sv
// ====================
// 1r1w RAM with synchronous read
// optional clock gate in front of the array
// same ports with and without gating
// ====================

`timescale 1ns/1ns

module ram_1r1w_sync
   #(
   parameter int width_p   = fifo_pkg::data_width_c,
   parameter int els_p     = fifo_pkg::depth_c,
   parameter bit gate_en_p = 1'b0
   )
   (
   input  logic            clk_lo,

   // write port
   input  logic            w_v_i,
   input  fifo_pkg::addr_t w_addr_i,
   input  fifo_pkg::data_t w_data_i,

   // read port
   input  logic            r_v_i,
   input  fifo_pkg::addr_t r_addr_i,
   output fifo_pkg::data_t r_data_o
   );

   // clock seen by the array
   logic array_clk;

   // the array needs a clock only in cycles where one of
   // the ports does something, idle cycles are gated off
   if (gate_en_p)
   begin : g_gated
      clock_gate i_clock_gate
         (
         .clk_lo      (clk_lo),
         .en_i        (w_v_i | r_v_i),
         .gated_clk_o (array_clk)
         );
   end
   else
   begin : g_ungated
      assign array_clk = clk_lo;
   end

   ram_1r1w_sync_array
      #(
      .width_p (width_p),
      .els_p   (els_p)
      )
   i_ram_1r1w_sync_array
      (
      .clk_lo   (array_clk),
      .w_v_i    (w_v_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_v_i    (r_v_i),
      .r_addr_i (r_addr_i),
      .r_data_o (r_data_o)
      );

endmodule

// File: ram_1r1w_sync_array.sv
// ====================
// storage array for the 1r1w RAM
// write on the rising edge
// registered synchronous read
// ====================

`timescale 1ns/1ns

module ram_1r1w_sync_array
   #(
   parameter int width_p = fifo_pkg::data_width_c,
   parameter int els_p   = fifo_pkg::depth_c
   )
   (
   input  logic            clk_lo,

   // write port
   input  logic            w_v_i,
   input  fifo_pkg::addr_t w_addr_i,
   input  fifo_pkg::data_t w_data_i,

   // read port
   input  logic            r_v_i,
   input  fifo_pkg::addr_t r_addr_i,
   output fifo_pkg::data_t r_data_o
   );

   import fifo_pkg::*;

   // the words themselves
   logic [width_p-1:0] mem [els_p];

   // read data register, holds the last word read
   data_t r_data_r;

   // write port
   // the word lands in the array on the edge of the strobe
   always_ff @(posedge clk_lo)
   begin
      if (w_v_i)
      begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read port
   // one cycle from strobe to data, the register keeps
   // its value in cycles without a read
   always_ff @(posedge clk_lo)
   begin
      if (r_v_i)
      begin
         r_data_r <= mem[r_addr_i];
      end
   end

   assign r_data_o = r_data_r;

endmodule

// File: clock_gate.sv
// ====================
// latch-based clock gate
// enable captured while the clock is low
// ====================

`timescale 1ns/1ns

module clock_gate
   (
   input  logic clk_lo,
   input  logic en_i,
   output logic gated_clk_o
   );

   logic en_latched;

   // transparent during the low phase only, so the enable
   // cannot change while the clock is high
   always_latch
   begin
      if (!clk_lo)
      begin
         en_latched = en_i;
      end
   end

   // no pulse can be cut short, the enable is frozen for the high phase
   assign gated_clk_o = clk_lo & en_latched;

endmodule

// File: fifo_pkg.sv
// ====================
// shared sizes and vector types for the sync FIFO
// default word width and depth
// word, index and fill-level vectors
// ====================

package fifo_pkg;

   // default word width in bits
   parameter int data_width_c = 16;

   // default number of FIFO entries
   parameter int depth_c = 8;

   // index width, kept at one bit or more for a single-entry FIFO
   parameter int addr_width_c = (depth_c > 1) ? $clog2(depth_c) : 1;

   // one extra bit so the count can reach depth_c itself
   parameter int count_width_c = addr_width_c + 1;

   // one FIFO word as stored in the RAM
   typedef logic [data_width_c-1:0] data_t;

   // entry index into the storage array
   typedef logic [addr_width_c-1:0] addr_t;

   // fill level, 0 through depth_c
   typedef logic [count_width_c-1:0] count_t;

endpackage
